//--- build.f
src/gomoku_pkg.sv
src/eval_ctrl.sv
src/line_matcher.sv
src/score_accum.sv
src/board_eval.sv
bench/board_eval_sva.sv
bench/board_eval_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the board evaluator testbench with Verilator and runs it.
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    -f build.f \
    --top-module board_eval_tb \
    --Mdir "$BUILD_DIR" \
    -o board_eval_sim

"./$BUILD_DIR/board_eval_sim" | tee "$LOG"

if grep -q "Finished with no errors" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi

//--- bench/board_eval_tb.sv
`timescale 1ns/1ps

module board_eval_tb
    import gomoku_pkg::*;
();

    localparam int MAX_CYCLES = 3000;
    localparam int HAND_SCORE = 1121100;  // five, open four, two blocked fours, three, two.

    logic   i_clk;
    logic   i_rst_n;
    logic   i_start;
    board_u i_board;
    score_t o_score;
    logic   o_finish;

    int     cycle  = 0;
    int     errors = 0;
    int     checks = 0;
    int     issued = 0;
    int     done   = 0;
    score_t exp_q[$];
    int     start_q[$];
    string  name_q[$];

    board_eval #(
        .BOARD_N (BOARD_N)
    ) dut (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (i_start),
        .i_board  (i_board),
        .o_score  (o_score),
        .o_finish (o_finish)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // C is an own stone, O an opponent stone and E an empty square.
    function automatic bit fits(line_t ln, int r, string pat, cell_t me);
        cell_t opp;
        cell_t want;
        opp = (me == CELL_BLACK) ? CELL_WHITE : CELL_BLACK;
        if (r + pat.len() > BOARD_N) return 1'b0;
        for (int k = 0; k < pat.len(); k++) begin
            case (pat[k])
                "C":     want = me;
                "O":     want = opp;
                default: want = CELL_EMPTY;
            endcase
            if (ln[r+k] != want) return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic int count_pat(line_t ln, string pat, cell_t me);
        int n;
        n = 0;
        for (int r = 0; r < BOARD_N; r++) begin
            if (fits(ln, r, pat, me)) n++;
        end
        return n;
    endfunction

    function automatic int player_total(line_t ln, cell_t me);
        return count_pat(ln, "CCCCC", me) * W_FIVE
             + count_pat(ln, "ECCCCE", me) * W_OPEN_FOUR
             + (count_pat(ln, "OCCCCE", me) + count_pat(ln, "ECCCCO", me)) * W_BLOCKED_FOUR
             + count_pat(ln, "ECCCE", me) * W_OPEN_THREE
             + count_pat(ln, "EECCEE", me) * W_OPEN_TWO;
    endfunction

    function automatic score_t ref_score(board_u b);
        line_t ln;
        int    total;
        total = 0;
        for (int c = 0; c < BOARD_N; c++) begin
            for (int r = 0; r < BOARD_N; r++) begin
                ln[r] = b.cells[r*BOARD_N + c];
            end
            total += player_total(ln, CELL_BLACK) - player_total(ln, CELL_WHITE);
        end
        return total;
    endfunction

    function automatic board_u empty_board();
        board_u b;
        for (int i = 0; i < BOARD_N*BOARD_N; i++) b.cells[i] = CELL_EMPTY;
        return b;
    endfunction

    function automatic board_u random_board();
        board_u b;
        for (int i = 0; i < BOARD_N*BOARD_N; i++) b.cells[i] = cell_t'(2'($urandom % 3));
        return b;
    endfunction

    // vertical run of len stones starting at row0.
    function automatic board_u put_run(board_u b, int col, int row0, int len, cell_t v);
        for (int r = row0; r < row0 + len; r++) b.cells[r*BOARD_N + col] = v;
        return b;
    endfunction

    // one pattern class per column for player me.
    function automatic board_u pattern_board(cell_t me, cell_t opp);
        board_u b;
        b = empty_board();
        b = put_run(b, 0, 2, 5, me);
        b = put_run(b, 2, 3, 4, me);
        b = put_run(b, 4, 0, 1, opp);
        b = put_run(b, 4, 1, 4, me);
        b = put_run(b, 6, 10, 4, me);
        b = put_run(b, 6, 14, 1, opp);
        b = put_run(b, 8, 5, 3, me);
        b = put_run(b, 10, 6, 2, me);
        return b;
    endfunction

    task automatic start_eval(board_u b, string name);
        @(posedge i_clk);
        #1;
        i_board = b;
        i_start = 1'b1;
        @(posedge i_clk);  // start edge.
        #1;
        i_start = 1'b0;
        exp_q.push_back(ref_score(b));
        start_q.push_back(cycle);
        name_q.push_back(name);
        issued++;
    endtask

    task automatic run_eval(board_u b, string name);
        start_eval(b, name);
        wait (done == issued);
    endtask

    initial begin
        while (cycle < MAX_CYCLES) begin
            @(posedge i_clk);
            cycle++;
        end
        $display("timeout: run still going after %0d cycles", MAX_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    // compares each finish against the oldest pending run.
    initial begin
        score_t exp_v;
        int     start_v;
        string  name_v;
        forever begin
            @(negedge i_clk);
            if (i_rst_n && o_finish !== 1'b0) begin
                checks++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("o_finish pulsed at cycle %0d with no run pending", cycle);
                end else begin
                    exp_v   = exp_q.pop_front();
                    start_v = start_q.pop_front();
                    name_v  = name_q.pop_front();
                    if (o_score !== exp_v) begin
                        errors++;
                        $display("mismatch in %s: o_score = %h, expected %h",
                                 name_v, o_score, exp_v);
                    end else if (cycle - start_v != EVAL_LATENCY) begin
                        errors++;
                        $display("%s finished %0d cycles after start instead of %0d",
                                 name_v, cycle - start_v, EVAL_LATENCY);
                    end else begin
                        $display("pass %s: score %h", name_v, o_score);
                    end
                    done++;
                end
            end
        end
    end

    initial begin
        board_u b;
        board_u other;
        void'($urandom(32'hd190));
        i_rst_n = 1'b0;
        i_start = 1'b0;
        i_board = empty_board();
        repeat (4) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        checks++;
        if (o_score !== '0) begin
            errors++;
            $display("mismatch after reset: o_score = %h, expected %h", o_score, 32'h0);
        end
        repeat (3) @(posedge i_clk);  // finish must stay low while idle.

        run_eval(empty_board(), "empty board");
        b = pattern_board(CELL_BLACK, CELL_WHITE);
        checks++;
        if (ref_score(b) != HAND_SCORE) begin
            errors++;
            $display("reference gives %0d for the black patterns, hand count is %0d",
                     ref_score(b), HAND_SCORE);
        end
        run_eval(b, "black patterns");
        run_eval(pattern_board(CELL_WHITE, CELL_BLACK), "white patterns");
        b = put_run(b, 12, 5, 3, CELL_WHITE);  // white open three beside black.
        run_eval(b, "mixed board");
        for (int n = 0; n < 40; n++) begin
            run_eval(random_board(), $sformatf("random board %0d", n));
        end

        // second start and new board while busy.
        b = random_board();
        other = random_board();
        start_eval(b, "start while busy");
        repeat (5) @(posedge i_clk);
        #1;
        i_start = 1'b1;
        i_board = other;
        @(posedge i_clk);
        #1;
        i_start = 1'b0;
        wait (done == issued);
        repeat (20) @(posedge i_clk);  // a stray finish would land here.

        $display("runs %0d, checks %0d, errors %0d", done, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- bench/board_eval_sva.sv
`timescale 1ns/1ps

module board_eval_sva
    import gomoku_pkg::*;
#(
    parameter int BOARD_N = gomoku_pkg::BOARD_N
) (
    input logic   i_clk,
    input logic   i_rst_n,
    input logic   i_start,
    input score_t o_score,
    input logic   o_finish
);

    localparam int LW = $clog2(BOARD_N + 1);

    logic [LW-1:0] left;  // columns still to issue.
    logic          idle;

    assign idle = (left == '0);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            left <= '0;
        end else if (i_start && idle) begin
            left <= LW'(BOARD_N);
        end else if (!idle) begin
            left <= left - 1'b1;
        end
    end

    a_finish_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_finish |=> !o_finish)
        else $error("o_finish high on two cycles in a row");

    // finish rises on the latency edge and shows in the sampled values one edge later.
    a_start_to_finish: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_start && idle) |=> ##EVAL_LATENCY o_finish)
        else $error("no o_finish %0d cycles after an accepted start", EVAL_LATENCY);

    // score may only move on the edge that raises finish.
    a_score_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_score != $past(o_score)) |-> o_finish)
        else $error("o_score changed without o_finish");

endmodule

bind board_eval board_eval_sva #(
    .BOARD_N (BOARD_N)
) u_sva (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_start  (i_start),
    .o_score  (o_score),
    .o_finish (o_finish)
);

//--- src/board_eval.sv
`timescale 1ns/1ps

module board_eval
    import gomoku_pkg::*;
#(
    parameter int BOARD_N = gomoku_pkg::BOARD_N
) (
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_start,
    input  board_u i_board,
    output score_t o_score,
    output logic   o_finish
);

    line_beat_t  line_beat;
    count_beat_t black_beat;
    count_beat_t white_beat;

    eval_ctrl #(
        .BOARD_N (BOARD_N)
    ) u_ctrl (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_board (i_board),
        .o_line  (line_beat)
    );

    // one matcher per player on the same column.
    line_matcher #(
        .BOARD_N (BOARD_N),
        .PLAYER  (CELL_BLACK)
    ) u_black (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_line   (line_beat),
        .o_counts (black_beat)
    );

    line_matcher #(
        .BOARD_N (BOARD_N),
        .PLAYER  (CELL_WHITE)
    ) u_white (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_line   (line_beat),
        .o_counts (white_beat)
    );

    score_accum u_accum (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_black  (black_beat),
        .i_white  (white_beat),
        .o_score  (o_score),
        .o_finish (o_finish)
    );

endmodule

//--- src/score_accum.sv
`timescale 1ns/1ps

module score_accum
    import gomoku_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  count_beat_t i_black,
    input  count_beat_t i_white,
    output score_t      o_score,
    output logic        o_finish
);

    score_t black_sum;
    score_t white_sum;
    score_t black_next;
    score_t white_next;

    function automatic score_t weigh(pattern_counts_t c);
        score_t s;
        s = score_t'(c.five) * W_FIVE
          + score_t'(c.open_four) * W_OPEN_FOUR
          + score_t'(c.blocked_four) * W_BLOCKED_FOUR
          + score_t'(c.open_three) * W_OPEN_THREE
          + score_t'(c.open_two) * W_OPEN_TWO;
        return s;
    endfunction

    // matcher beats are aligned, marks come from the black side.
    always_comb begin
        black_next = (i_black.first ? '0 : black_sum) + weigh(i_black.counts);
        white_next = (i_black.first ? '0 : white_sum) + weigh(i_white.counts);
    end

    always_ff @(posedge i_clk) begin
        if (i_black.valid) begin
            black_sum <= black_next;
            white_sum <= white_next;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_score  <= '0;
            o_finish <= 1'b0;
        end else begin
            o_finish <= i_black.valid && i_black.last;
            if (i_black.valid && i_black.last) begin
                o_score <= black_next - white_next;  // black minus white.
            end
        end
    end

endmodule

//--- src/line_matcher.sv
`timescale 1ns/1ps

module line_matcher
    import gomoku_pkg::*;
#(
    parameter int    BOARD_N = gomoku_pkg::BOARD_N,
    parameter cell_t PLAYER  = CELL_BLACK
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  line_beat_t  i_line,
    output count_beat_t o_counts
);

    localparam cell_t OPPONENT = (PLAYER == CELL_BLACK) ? CELL_WHITE : CELL_BLACK;

    logic [BOARD_N-1:0] is_c;  // own stone.
    logic [BOARD_N-1:0] is_o;  // opponent stone.
    logic [BOARD_N-1:0] is_e;  // empty square.

    pattern_counts_t cnt;

    // code 3 sets none of the three flags.
    always_comb begin
        for (int i = 0; i < BOARD_N; i++) begin
            is_c[i] = (i_line.line[i] == PLAYER);
            is_o[i] = (i_line.line[i] == OPPONENT);
            is_e[i] = (i_line.line[i] == CELL_EMPTY);
        end
    end

    // every window is tested, overlaps count separately.
    always_comb begin
        cnt = '0;

        for (int i = 0; i + 5 <= BOARD_N; i++) begin
            if (&is_c[i +: 5]) begin
                cnt.five = cnt.five + 4'd1;
            end
            if (is_e[i] && (&is_c[i+1 +: 3]) && is_e[i+4]) begin
                cnt.open_three = cnt.open_three + 4'd1;
            end
        end

        for (int i = 0; i + 6 <= BOARD_N; i++) begin
            if (is_e[i] && (&is_c[i+1 +: 4]) && is_e[i+5]) begin
                cnt.open_four = cnt.open_four + 4'd1;
            end
            if (is_o[i] && (&is_c[i+1 +: 4]) && is_e[i+5]) begin
                cnt.blocked_four = cnt.blocked_four + 4'd1;  // blocked on top.
            end
            if (is_e[i] && (&is_c[i+1 +: 4]) && is_o[i+5]) begin
                cnt.blocked_four = cnt.blocked_four + 4'd1;  // blocked below.
            end
            if ((&is_e[i +: 2]) && (&is_c[i+2 +: 2]) && (&is_e[i+4 +: 2])) begin
                cnt.open_two = cnt.open_two + 4'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_counts.valid <= 1'b0;
        end else begin
            o_counts.valid <= i_line.valid;
        end
    end

    // marks and counts follow the beat.
    always_ff @(posedge i_clk) begin
        o_counts.first  <= i_line.first;
        o_counts.last   <= i_line.last;
        o_counts.counts <= cnt;
    end

endmodule

//--- src/eval_ctrl.sv
`timescale 1ns/1ps

module eval_ctrl
    import gomoku_pkg::*;
#(
    parameter int BOARD_N = gomoku_pkg::BOARD_N
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  board_u     i_board,
    output line_beat_t o_line
);

    localparam int CW = $clog2(BOARD_N);
    localparam logic [CW-1:0] LAST_COL = CW'(BOARD_N - 1);

    board_u        board_q;
    logic          busy;
    logic [CW-1:0] col;
    logic          accept;

    // start is honoured only while idle.
    assign accept = i_start && !busy;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy <= 1'b0;
            col  <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            col  <= '0;
        end else if (busy) begin
            if (col == LAST_COL) begin
                busy <= 1'b0;  // back to idle after the last column.
                col  <= '0;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            board_q <= i_board;
        end
    end

    // current column out of the latched board, top row first.
    always_comb begin
        o_line.valid = busy;
        o_line.first = (col == '0);
        o_line.last  = (col == LAST_COL);
        for (int r = 0; r < BOARD_N; r++) begin
            o_line.line[r] = board_q.rows[r][col];
        end
    end

endmodule

//--- src/gomoku_pkg.sv
package gomoku_pkg;

    // side of the square board.
    localparam int BOARD_N = 15;

    // cycles from the start edge to the finish edge.
    localparam int EVAL_LATENCY = 16;

    typedef enum logic [1:0] {
        CELL_BLACK = 2'd0,
        CELL_WHITE = 2'd1,
        CELL_EMPTY = 2'd2
    } cell_t;

    // flat view indexed row * BOARD_N + column; rows view indexed [row][column].
    typedef union packed {
        cell_t [BOARD_N*BOARD_N-1:0]     cells;
        cell_t [BOARD_N-1:0][BOARD_N-1:0] rows;
    } board_u;

    // one column, element 0 is the top row.
    typedef cell_t [BOARD_N-1:0] line_t;

    typedef struct packed {
        logic  valid;
        logic  first;  // column 0.
        logic  last;   // last column.
        line_t line;
    } line_beat_t;

    typedef struct packed {
        logic [3:0] five;
        logic [3:0] open_four;
        logic [3:0] blocked_four;
        logic [3:0] open_three;
        logic [3:0] open_two;
    } pattern_counts_t;

    typedef struct packed {
        logic            valid;
        logic            first;
        logic            last;
        pattern_counts_t counts;
    } count_beat_t;

    typedef logic signed [31:0] score_t;

    // pattern weights.
    localparam score_t W_FIVE         = 32'sd1000000;
    localparam score_t W_OPEN_FOUR    = 32'sd100000;
    localparam score_t W_BLOCKED_FOUR = 32'sd10000;
    localparam score_t W_OPEN_THREE   = 32'sd1000;
    localparam score_t W_OPEN_TWO     = 32'sd100;

endpackage
